// File: cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath widths
`define CPU_DATA_W      4
`define CPU_IDX_W       8
`define CPU_PC_W        12
`define CPU_INSTR_W     12

// Data RAM words, one per X/Y index value
`define CPU_RAM_DEPTH   256

// Execute phase length in clocks
`define CPU_EXEC_CYCLES 7

`endif

// File: cpu_isa_pkg.sv
`include "cpu_cfg.svh"

package cpu_isa_pkg;

    // Operation kinds recognised by the decoder
    typedef enum logic [3:0] {
        OP_NOP,
        OP_CP_XH,
        OP_CP_XL,
        OP_CP_YH,
        OP_CP_YL,
        OP_CP_RI,
        OP_CP_RQ,
        OP_LD_RI,
        OP_LD_X,
        OP_LD_Y
    } op_e;

    // r / q operand codes
    typedef enum logic [1:0] {
        R_A  = 2'd0,
        R_B  = 2'd1,
        R_MX = 2'd2,    // RAM at X
        R_MY = 2'd3     // RAM at Y
    } rsel_e;

    typedef struct packed {
        op_e                   op;
        rsel_e                 r;
        rsel_e                 q;
        logic [`CPU_IDX_W-1:0] imm;    // i in low nibble, or full e
    } dec_op_t;

    // Compare ops touch the flags, nothing else
    function automatic logic is_cp(op_e op);
        return op inside {OP_CP_XH, OP_CP_XL, OP_CP_YH, OP_CP_YL,
                          OP_CP_RI, OP_CP_RQ};
    endfunction

endpackage

// File: cpu_bus_pkg.sv
`include "cpu_cfg.svh"

package cpu_bus_pkg;

    // Program memory request, addr held while req is high
    typedef struct packed {
        logic                  req;
        logic [`CPU_PC_W-1:0]  addr;
    } fetch_req_t;

    typedef struct packed {
        logic                    ack;
        logic [`CPU_INSTR_W-1:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic carry;    // First operand below second
        logic zero;     // Operands equal
    } flags_t;

    // Architectural state seen from outside the core
    typedef struct packed {
        logic [`CPU_DATA_W-1:0] a;
        logic [`CPU_DATA_W-1:0] b;
        logic [`CPU_IDX_W-1:0]  x;
        logic [`CPU_IDX_W-1:0]  y;
        logic [`CPU_PC_W-1:0]   pc;
    } reg_view_t;

endpackage

// File: cpu_seq_fsm.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_seq_fsm (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,
    input  cpu_bus_pkg::fetch_rsp_t fetch_rsp,
    output cpu_bus_pkg::fetch_req_t fetch_req,
    input  logic [`CPU_PC_W-1:0]    pc,
    output logic [`CPU_INSTR_W-1:0] instr,
    output logic                    exec_start,
    input  logic                    exec_last,
    output logic                    commit,
    output logic                    done
);

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        RELEASE,
        EXECUTE,
        COMMIT
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (run) begin
                    state_nxt = REQ;
                end
            end
            REQ: begin
                if (fetch_rsp.ack) begin
                    state_nxt = RELEASE;
                end
            end
            RELEASE: begin
                // Return to zero before execute
                if (!fetch_rsp.ack) begin
                    state_nxt = EXECUTE;
                end
            end
            EXECUTE: begin
                if (exec_last) begin
                    state_nxt = COMMIT;
                end
            end
            COMMIT: begin
                state_nxt = run ? REQ : IDLE;    // run only checked between instructions
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // First cycle with ack high
    always_ff @(posedge clk) begin
        if (state == REQ && fetch_rsp.ack) begin
            instr <= fetch_rsp.data;
        end
    end

    always_comb begin
        fetch_req.req  = (state == REQ);
        fetch_req.addr = pc;    // PC only moves on commit
    end

    assign exec_start = (state == RELEASE) && !fetch_rsp.ack;
    assign commit     = (state == COMMIT);
    assign done       = (state == COMMIT);

endmodule

// File: cpu_cycle_timer.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_cycle_timer (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic last
);

    localparam int CNT_W = $clog2(`CPU_EXEC_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    // Loaded on start, parks at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= CNT_W'(`CPU_EXEC_CYCLES);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // High on the final execute cycle
    assign last = (cnt == CNT_W'(1));

endmodule

// File: cpu_decoder.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_decoder (
    input  logic [`CPU_INSTR_W-1:0] instr,
    output cpu_isa_pkg::dec_op_t    op
);

    localparam int PAD_W = `CPU_IDX_W - `CPU_DATA_W;

    always_comb begin
        op.op  = cpu_isa_pkg::OP_NOP;
        op.r   = cpu_isa_pkg::rsel_e'(instr[5:4]);
        op.q   = cpu_isa_pkg::R_A;
        op.imm = {{PAD_W{1'b0}}, instr[`CPU_DATA_W-1:0]};    // Nibble immediate

        casez (instr)
            12'hA4?: begin
                op.op = cpu_isa_pkg::OP_CP_XH;
            end
            12'hA5?: begin
                op.op = cpu_isa_pkg::OP_CP_XL;
            end
            12'hA6?: begin
                op.op = cpu_isa_pkg::OP_CP_YH;
            end
            12'hA7?: begin
                op.op = cpu_isa_pkg::OP_CP_YL;
            end
            12'b1101_11??_????: begin
                op.op = cpu_isa_pkg::OP_CP_RI;
            end
            12'hF0?: begin
                // Register pair packed in the low nibble
                op.op = cpu_isa_pkg::OP_CP_RQ;
                op.r  = cpu_isa_pkg::rsel_e'(instr[3:2]);
                op.q  = cpu_isa_pkg::rsel_e'(instr[1:0]);
            end
            12'b1110_00??_????: begin
                op.op = cpu_isa_pkg::OP_LD_RI;
            end
            12'hB??: begin
                op.op  = cpu_isa_pkg::OP_LD_X;
                op.imm = instr[`CPU_IDX_W-1:0];
            end
            12'h8??: begin
                op.op  = cpu_isa_pkg::OP_LD_Y;
                op.imm = instr[`CPU_IDX_W-1:0];
            end
            default: begin
                op.op = cpu_isa_pkg::OP_NOP;    // Unknown opcodes only bump the PC
            end
        endcase
    end

endmodule

// File: cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_regfile (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     commit,
    input  cpu_isa_pkg::dec_op_t     op,
    input  logic [`CPU_DATA_W-1:0]   wdata,
    output logic [`CPU_DATA_W-1:0]   opnd_r,
    output logic [`CPU_DATA_W-1:0]   opnd_q,
    output cpu_bus_pkg::reg_view_t   view
);

    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] b;
    logic [`CPU_IDX_W-1:0]  x;
    logic [`CPU_IDX_W-1:0]  y;
    logic [`CPU_PC_W-1:0]   pc;

    logic [`CPU_DATA_W-1:0] ram [`CPU_RAM_DEPTH];
    logic [`CPU_DATA_W-1:0] mx;
    logic [`CPU_DATA_W-1:0] my;
    logic                   ld_ri;
    logic                   ram_we;
    logic [`CPU_IDX_W-1:0]  ram_addr;

    function automatic logic [`CPU_DATA_W-1:0] pick(
        input cpu_isa_pkg::rsel_e    sel,
        input logic [`CPU_DATA_W-1:0] va,
        input logic [`CPU_DATA_W-1:0] vb,
        input logic [`CPU_DATA_W-1:0] vmx,
        input logic [`CPU_DATA_W-1:0] vmy
    );
        case (sel)
            cpu_isa_pkg::R_A:  return va;
            cpu_isa_pkg::R_B:  return vb;
            cpu_isa_pkg::R_MX: return vmx;
            default:           return vmy;
        endcase
    endfunction

    assign mx     = ram[x];
    assign my     = ram[y];
    assign opnd_r = pick(op.r, a, b, mx, my);
    assign opnd_q = pick(op.q, a, b, mx, my);

    assign ld_ri    = commit && (op.op == cpu_isa_pkg::OP_LD_RI);
    assign ram_we   = ld_ri && (op.r == cpu_isa_pkg::R_MX || op.r == cpu_isa_pkg::R_MY);
    assign ram_addr = (op.r == cpu_isa_pkg::R_MY) ? y : x;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a  <= '0;
            b  <= '0;
            x  <= '0;
            y  <= '0;
            pc <= '0;
        end else if (commit) begin
            pc <= pc + 1'b1;    // Every op, NOP included
            if (ld_ri && op.r == cpu_isa_pkg::R_A) begin
                a <= wdata;
            end
            if (ld_ri && op.r == cpu_isa_pkg::R_B) begin
                b <= wdata;
            end
            if (op.op == cpu_isa_pkg::OP_LD_X) begin
                x <= op.imm;
            end
            if (op.op == cpu_isa_pkg::OP_LD_Y) begin
                y <= op.imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[ram_addr] <= wdata;
        end
    end

    always_comb begin
        view.a  = a;
        view.b  = b;
        view.x  = x;
        view.y  = y;
        view.pc = pc;
    end

endmodule

// File: cpu_alu.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_alu (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   commit,
    input  cpu_isa_pkg::dec_op_t   op,
    input  logic [`CPU_DATA_W-1:0] opnd_r,
    input  logic [`CPU_DATA_W-1:0] opnd_q,
    input  logic [`CPU_IDX_W-1:0]  x,
    input  logic [`CPU_IDX_W-1:0]  y,
    output logic [`CPU_DATA_W-1:0] wdata,
    output cpu_bus_pkg::flags_t    flags
);

    logic [`CPU_DATA_W-1:0] imm_nib;
    logic [`CPU_DATA_W-1:0] lhs;
    logic [`CPU_DATA_W-1:0] rhs;
    cpu_bus_pkg::flags_t    flags_nxt;

    assign imm_nib = op.imm[`CPU_DATA_W-1:0];
    assign wdata   = imm_nib;    // LD r,i value

    // Default pair is r against i
    always_comb begin
        lhs = opnd_r;
        rhs = imm_nib;
        case (op.op)
            cpu_isa_pkg::OP_CP_XH: lhs = x[`CPU_IDX_W-1:`CPU_DATA_W];
            cpu_isa_pkg::OP_CP_XL: lhs = x[`CPU_DATA_W-1:0];
            cpu_isa_pkg::OP_CP_YH: lhs = y[`CPU_IDX_W-1:`CPU_DATA_W];
            cpu_isa_pkg::OP_CP_YL: lhs = y[`CPU_DATA_W-1:0];
            cpu_isa_pkg::OP_CP_RQ: rhs = opnd_q;
            default:               rhs = imm_nib;
        endcase
    end

    always_comb begin
        flags_nxt.carry = (lhs < rhs);    // Borrow out of lhs - rhs
        flags_nxt.zero  = (lhs == rhs);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (commit && cpu_isa_pkg::is_cp(op.op)) begin
            flags <= flags_nxt;
        end
    end

endmodule

// File: cpu_core.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_core (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,
    output cpu_bus_pkg::fetch_req_t fetch_req,
    input  cpu_bus_pkg::fetch_rsp_t fetch_rsp,
    output logic                    done,
    output cpu_bus_pkg::flags_t     flags,
    output cpu_bus_pkg::reg_view_t  regs
);

    logic [`CPU_INSTR_W-1:0] instr;
    logic                    exec_start;
    logic                    exec_last;
    logic                    commit;
    cpu_isa_pkg::dec_op_t    dec_op;
    logic [`CPU_DATA_W-1:0]  wdata;
    logic [`CPU_DATA_W-1:0]  opnd_r;
    logic [`CPU_DATA_W-1:0]  opnd_q;

    cpu_seq_fsm seq_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .fetch_rsp  (fetch_rsp),
        .fetch_req  (fetch_req),
        .pc         (regs.pc),
        .instr      (instr),
        .exec_start (exec_start),
        .exec_last  (exec_last),
        .commit     (commit),
        .done       (done)
    );

    // Sets the execute length
    cpu_cycle_timer timer_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (exec_start),
        .last   (exec_last)
    );

    cpu_decoder dec_i (
        .instr (instr),
        .op    (dec_op)
    );

    cpu_regfile rf_i (
        .clk    (clk),
        .arst_n (arst_n),
        .commit (commit),
        .op     (dec_op),
        .wdata  (wdata),
        .opnd_r (opnd_r),
        .opnd_q (opnd_q),
        .view   (regs)
    );

    // Holds the flag register
    cpu_alu alu_i (
        .clk    (clk),
        .arst_n (arst_n),
        .commit (commit),
        .op     (dec_op),
        .opnd_r (opnd_r),
        .opnd_q (opnd_q),
        .x      (regs.x),
        .y      (regs.y),
        .wdata  (wdata),
        .flags  (flags)
    );

endmodule

// File: tb_cpu_core.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu_core;

    localparam int DONE_TIMEOUT = 40;

    logic                    clk = 1'b0;
    logic                    arst_n = 1'b0;
    logic                    run = 1'b0;
    cpu_bus_pkg::fetch_req_t fetch_req;
    cpu_bus_pkg::fetch_rsp_t fetch_rsp = '0;
    logic                    done;
    cpu_bus_pkg::flags_t     flags;
    cpu_bus_pkg::reg_view_t  regs;

    integer seed = 32'h2e229d99;
    int     cyc = 0;
    int     ack_fall_cyc = 0;
    int     ack_wait = -1;    // -1 while no delay is drawn
    int     prog_len = 0;
    int     n_new = 0;
    logic   chk_pending = 1'b0;
    string  test_name = "reset_idle";
    logic [`CPU_DATA_W-1:0]  val;

    logic [`CPU_INSTR_W-1:0] prog_mem [0:(1 << `CPU_PC_W) - 1];

    // Reference model state
    cpu_bus_pkg::reg_view_t  model = '0;
    cpu_bus_pkg::flags_t     model_flags = '0;
    logic [`CPU_DATA_W-1:0]  model_ram [`CPU_RAM_DEPTH];

    cpu_core cpu_core_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .done      (done),
        .flags     (flags),
        .regs      (regs)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_flags(input string name, input cpu_bus_pkg::flags_t exp,
                               input cpu_bus_pkg::flags_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s flags: expected c=%b z=%b, actual c=%b z=%b",
                     name, exp.carry, exp.zero, act.carry, act.zero);
            stop_on_error();
        end
    endtask

    task automatic check_regs(input string name, input cpu_bus_pkg::reg_view_t exp,
                              input cpu_bus_pkg::reg_view_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s regs (a b x y pc): expected %h, actual %h",
                     name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input logic [`CPU_PC_W-1:0] exp,
                              input logic [`CPU_PC_W-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s fetch addr: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s latency: expected %0d, actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    function automatic cpu_bus_pkg::flags_t cp_ref(input logic [`CPU_DATA_W-1:0] lhs,
                                                   input logic [`CPU_DATA_W-1:0] rhs);
        cpu_bus_pkg::flags_t f;
        f.carry = lhs < rhs;
        f.zero  = lhs == rhs;
        return f;
    endfunction

    function automatic logic [`CPU_DATA_W-1:0] operand(input logic [1:0] sel);
        case (sel)
            2'd0:    return model.a;
            2'd1:    return model.b;
            2'd2:    return model_ram[model.x];
            default: return model_ram[model.y];
        endcase
    endfunction

    task automatic step_model(input logic [`CPU_INSTR_W-1:0] w);
        casez (w)
            12'hA4?: model_flags = cp_ref(model.x[7:4], w[3:0]);
            12'hA5?: model_flags = cp_ref(model.x[3:0], w[3:0]);
            12'hA6?: model_flags = cp_ref(model.y[7:4], w[3:0]);
            12'hA7?: model_flags = cp_ref(model.y[3:0], w[3:0]);
            12'b1101_11??_????: model_flags = cp_ref(operand(w[5:4]), w[3:0]);
            12'hF0?: model_flags = cp_ref(operand(w[3:2]), operand(w[1:0]));
            12'b1110_00??_????: begin
                case (w[5:4])
                    2'd0:    model.a = w[3:0];
                    2'd1:    model.b = w[3:0];
                    2'd2:    model_ram[model.x] = w[3:0];
                    default: model_ram[model.y] = w[3:0];
                endcase
            end
            12'hB??: model.x = w[7:0];
            12'h8??: model.y = w[7:0];
        endcase
        model.pc = model.pc + 1'b1;    // Undefined words too
    endtask

    task automatic emit(input logic [`CPU_INSTR_W-1:0] w);
        prog_mem[prog_len] = w;
        prog_len++;
        n_new++;
    endtask

    // Runs the queued words and drops run together with the last done
    task automatic run_test(input string name);
        int seen;
        int wait_cyc;
        seen = 0;
        test_name = name;
        @(negedge clk);
        run <= 1'b1;
        while (seen < n_new) begin
            wait_cyc = 0;
            do begin
                @(negedge clk);
                wait_cyc++;
                if (wait_cyc > DONE_TIMEOUT) begin
                    $display("Timeout in %s: %s", name, fetch_req.req ?
                             "fetch req never acknowledged" : "no done after the fetch");
                    stop_on_error();
                end
            end while (!done);
            seen++;
            if (seen == n_new) begin
                run <= 1'b0;
            end
        end
        n_new = 0;
        repeat (2) @(negedge clk);    // Last compare happens in between
    endtask

    // Program memory with 0 to 3 cycles of ack delay
    always @(negedge clk) begin
        if (fetch_req.req && !fetch_rsp.ack) begin
            check_addr(test_name, model.pc, fetch_req.addr);    // Must follow the PC
            if (ack_wait < 0) begin
                ack_wait = $unsigned($random(seed)) % 4;
            end
            if (ack_wait == 0) begin
                fetch_rsp.data <= prog_mem[fetch_req.addr];
                fetch_rsp.ack  <= 1'b1;
            end
            ack_wait = ack_wait - 1;
        end else if (!fetch_req.req && fetch_rsp.ack) begin
            fetch_rsp.ack <= 1'b0;
            ack_fall_cyc = cyc;
        end
    end

    // Model steps at done and the DUT state is compared one cycle later
    always @(negedge clk) begin
        if (chk_pending) begin
            check_flags(test_name, model_flags, flags);
            check_regs(test_name, model, regs);
            chk_pending = 1'b0;
        end
        if (done) begin
            check_latency(test_name, `CPU_EXEC_CYCLES + 1, cyc - ack_fall_cyc);
            step_model(prog_mem[model.pc]);
            chk_pending = 1'b1;
        end
    end

    initial begin
        repeat (8) @(negedge clk);
        arst_n <= 1'b1;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            if (fetch_req.req || done) begin
                $display("req or done went high while run was low after reset");
                stop_on_error();
            end
        end
        check_regs(test_name, '0, regs);
        check_flags(test_name, '0, flags);

        // Each index half against its nibble plus one then equal then minus one
        emit(12'hB7C);
        emit(12'h83E);
        for (int k = 0; k < 3; k++) begin
            emit({8'hA4, 4'(8 - k)});
            emit({8'hA5, 4'(13 - k)});
            emit({8'hA6, 4'(4 - k)});
            emit({8'hA7, 4'(15 - k)});
        end
        run_test("index_compare");

        for (int r = 0; r < 4; r++) begin
            emit({4'hB, 8'($random(seed))});
            emit({4'h8, 8'($random(seed))});
            val = 4'($random(seed));
            emit({6'b111000, 2'(r), val});
            emit({6'b110111, 2'(r), 4'($random(seed))});
            emit({6'b110111, 2'(r), 4'($random(seed))});
            emit({6'b110111, 2'(r), val});    // Reads back equal
        end
        run_test("load_compare_imm");

        for (int p = 0; p < 16; p++) begin
            emit({4'hB, 8'($random(seed))});
            emit({4'h8, 8'($random(seed))});
            for (int r = 0; r < 4; r++) begin
                emit({6'b111000, 2'(r), 4'($random(seed))});
            end
            emit({8'hF0, 2'(p / 4), 2'(p)});
        end
        run_test("compare_reg_pair");

        for (int k = 0; k < 8; k++) begin
            emit({6'b111000, 2'd1, 4'($random(seed))});
        end
        run_test("ack_latency");

        // Words outside every opcode pattern
        emit(12'h000);
        emit(12'hFFF);
        emit(12'hE40);
        emit(12'hDB5);
        run_test("undefined_opcode");

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
cpu_isa_pkg.sv
cpu_bus_pkg.sv
cpu_seq_fsm.sv
cpu_cycle_timer.sv
cpu_decoder.sv
cpu_regfile.sv
cpu_alu.sv
cpu_core.sv
tb_cpu_core.sv
